// ==== instr.hex ====
// one 32-bit instruction word per line, word addresses 0 to 31
// the byte address of a word is four times its line number
00000093
00100113
00208193
40110233
0041a2b3
00512333
006283b3
00731433
0083c4b3
00946533
00a4f5b3
00b56633
00c5e6b3
00d66733
00e6e7b3
00f76833
10000897
01088893
0008a903
0048a983
01390a33
0148a423
00190913
fff98993
fe0994e3
00a00513
00b00593
00b50633
00c6a023
0000006f
00000013
00008067

// ==== list.f ====
design/ifetch_pkg.sv
design/fetch_if.sv
design/mem_if.sv
design/icache.sv
design/fetch_unit.sv
design/instr_mem.sv
design/ifetch_top.sv
tb/ifetch_props.sv
tb/ifetch_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ifetch_tb -f list.f -o ifetch_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/ifetch_sim > sim.log 2>&1
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation failed"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

// ==== tb/ifetch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ifetch_tb import ifetch_pkg::*; ();

    // fetched words over all tests, 40 cycles allowed for each
    localparam int WORDS_TOTAL = 68;
    localparam int CYCLE_LIMIT = 40 * WORDS_TOTAL;

    logic                  clk;
    logic                  rst;
    logic                  redirect_valid;
    logic [XLEN-1:0]       redirect_pc;
    logic                  instr_ready;
    logic                  flush;
    logic                  instr_valid;
    logic [XLEN-1:0]       instr_pc;
    logic [XLEN-1:0]       instr_data;
    logic [MISS_CNT_W-1:0] miss_count;

    logic [XLEN-1:0] program_words [MEM_WORDS];
    logic [15:0]     lfsr_state;
    int              cycle_count;

    ifetch_top UUT (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .instr_ready    (instr_ready),
        .flush          (flush),
        .instr_valid    (instr_valid),
        .instr_pc       (instr_pc),
        .instr_data     (instr_data),
        .miss_count     (miss_count)
    );

    bind ifetch_top ifetch_props u_props (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .instr_ready    (instr_ready),
        .instr_valid    (instr_valid),
        .instr_pc       (instr_pc),
        .instr_data     (instr_data),
        .mem_req_valid  (mem_bus.req_valid),
        .mem_req_ready  (mem_bus.req_ready),
        .mem_resp_valid (mem_bus.resp_valid)
    );

    always #20 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // program wraps every 32 words
    function automatic logic [XLEN-1:0] expected_word(input logic [XLEN-1:0] addr);
        return program_words[addr[6:2]];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_count(input string name, input logic [MISS_CNT_W-1:0] got,
                               input logic [MISS_CNT_W-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp));
    endtask

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
            abort_run($sformatf("timeout: fetch stream stuck after %0d cycles", CYCLE_LIMIT));
    end

    // hold keeps the word in the buffer so nothing is fetched behind it
    task automatic take_word(input logic [XLEN-1:0] pc_exp, input bit hold, input bit stall);
        bit seen;
        seen = 1'b0;
        while (!seen)
        begin
            if (hold)
                instr_ready <= 1'b0;
            else if (stall)
            begin
                lfsr_state = lfsr_step(lfsr_state);
                instr_ready <= lfsr_state[0];
            end
            else
                instr_ready <= 1'b1;
            @(posedge clk);
            if (instr_valid && (instr_ready || hold))
            begin
                check_word("instr_pc", instr_pc, pc_exp);
                check_word("instr_data", instr_data, expected_word(pc_exp));
                seen = 1'b1;
            end
        end
    endtask

    task automatic fetch_words(input logic [XLEN-1:0] start, input int count, input bit stall);
        for (int i = 0; i < count; i++)
            take_word(start + XLEN'(4 * i), i == count - 1, stall);
    endtask

    task automatic redirect_to(input logic [XLEN-1:0] target);
        redirect_valid <= 1'b1;
        redirect_pc    <= target;
        instr_ready    <= 1'b0;
        @(posedge clk);
        redirect_valid <= 1'b0;
    endtask

    task automatic pulse_flush();
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic test_cold_fetch();
        fetch_words(RESET_PC, 16, 1'b0);
        check_count("miss_count", miss_count, MISS_CNT_W'(16));
    endtask

    task automatic test_loop_hits();
        redirect_to(32'h0);
        fetch_words(32'h0, 16, 1'b0);
        check_count("miss_count", miss_count, MISS_CNT_W'(16));
    endtask

    // 0x40 maps onto the same lines as 0x00 with another tag
    task automatic test_conflict();
        redirect_to(32'h40);
        fetch_words(32'h40, 4, 1'b0);
        check_count("miss_count", miss_count, MISS_CNT_W'(20));
        redirect_to(32'h0);
        fetch_words(32'h0, 4, 1'b0);
        check_count("miss_count", miss_count, MISS_CNT_W'(24));
    endtask

    task automatic test_flush();
        redirect_to(32'h10);
        fetch_words(32'h10, 4, 1'b0);
        check_count("miss_count", miss_count, MISS_CNT_W'(24));
        pulse_flush();
        redirect_to(32'h10);
        fetch_words(32'h10, 4, 1'b0);
        check_count("miss_count", miss_count, MISS_CNT_W'(28));
    endtask

    // runs across the 128 byte wrap of the memory
    task automatic test_backpressure();
        redirect_to(32'h60);
        fetch_words(32'h60, 16, 1'b1);
    endtask

    task automatic test_redirect_in_flight();
        bit taken;
        bit accepted;
        taken    = 1'b0;
        accepted = 1'b0;
        // release the held word so the fetch of 0xa0 starts
        instr_ready <= 1'b1;
        while (!taken)
        begin
            @(posedge clk);
            taken = instr_valid && instr_ready;
        end
        instr_ready <= 1'b0;
        while (!accepted)
        begin
            @(posedge clk);
            accepted = UUT.fetch_bus.req_valid && UUT.fetch_bus.req_ready;
        end
        check_word("fetch req_addr", UUT.fetch_bus.req_addr, 32'ha0);
        redirect_to(32'h08);
        fetch_words(32'h08, 3, 1'b0);
    endtask

    initial
    begin
        clk            = 1'b0;
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        instr_ready    = 1'b0;
        flush          = 1'b0;
        lfsr_state     = 16'd54700;
        cycle_count    = 0;
        $readmemh("instr.hex", program_words);
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        test_cold_fetch();
        test_loop_hits();
        test_conflict();
        test_flush();
        test_backpressure();
        test_redirect_in_flight();

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/ifetch_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module ifetch_props import ifetch_pkg::*;
(
    input wire            clk,
    input wire            rst,
    input wire            redirect_valid,
    input wire            instr_ready,
    input wire            instr_valid,
    input wire [XLEN-1:0] instr_pc,
    input wire [XLEN-1:0] instr_data,
    input wire            mem_req_valid,
    input wire            mem_req_ready,
    input wire            mem_resp_valid
);

    // a stalled word holds until taken, a redirect may drop it
    property p_stall_stable;
        @(posedge clk) disable iff (rst)
        (instr_valid && !instr_ready && !redirect_valid)
            |=> (instr_valid && $stable(instr_pc) && $stable(instr_data));
    endproperty

    property p_mem_latency;
        @(posedge clk) disable iff (rst)
        mem_resp_valid |-> $past(mem_req_valid && mem_req_ready, MEM_LATENCY);
    endproperty

    property p_reset_empty;
        @(posedge clk)
        rst |=> !instr_valid;
    endproperty

    a_stall_stable: assert property (p_stall_stable)
        else $error("instr stream changed while stalled");
    a_mem_latency: assert property (p_mem_latency)
        else $error("memory response without a request three cycles before");
    a_reset_empty: assert property (p_reset_empty)
        else $error("instr_valid high right after reset");

endmodule

`default_nettype wire

// ==== design/ifetch_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ifetch_top import ifetch_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   redirect_valid,
    input  wire  [XLEN-1:0]       redirect_pc,
    input  wire                   instr_ready,
    input  wire                   flush,
    output logic                  instr_valid,
    output logic [XLEN-1:0]       instr_pc,
    output logic [XLEN-1:0]       instr_data,
    output logic [MISS_CNT_W-1:0] miss_count
);

    fetch_if fetch_bus ();
    mem_if   mem_bus ();

    fetch_unit u_fetch (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .instr_ready    (instr_ready),
        .instr_valid    (instr_valid),
        .instr_pc       (instr_pc),
        .instr_data     (instr_data),
        .fetch          (fetch_bus.requester)
    );

    icache u_icache (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .miss_count (miss_count),
        .cpu        (fetch_bus.responder),
        .mem        (mem_bus.requester)
    );

    instr_mem u_mem (
        .clk (clk),
        .rst (rst),
        .bus (mem_bus.responder)
    );

endmodule

`default_nettype wire

// ==== design/instr_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_mem import ifetch_pkg::*;
(
    input wire       clk,
    input wire       rst,
    mem_if.responder bus
);

    logic [XLEN-1:0]      words [MEM_WORDS];
    logic                 busy;
    logic [MEM_CNT_W-1:0] cnt;
    logic [MEM_IDX_W-1:0] word_q;

    initial
    begin
        $readmemh("instr.hex", words);
    end

    assign bus.req_ready  = !busy;
    // word is out MEM_LATENCY cycles after the transfer
    assign bus.resp_valid = busy && (cnt == '0);
    assign bus.resp_data  = words[word_q];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            cnt  <= '0;
        end
        else if (bus.req_valid && bus.req_ready)
        begin
            busy <= 1'b1;
            cnt  <= MEM_CNT_W'(MEM_LATENCY - 1);
        end
        else if (busy)
        begin
            if (cnt == '0)
                busy <= 1'b0;
            else
                cnt <= cnt - 1'b1;
        end
    end

    // address bits 6:2, upper bits wrap
    always_ff @(posedge clk)
    begin
        if (bus.req_valid && bus.req_ready)
            word_q <= bus.req_addr[MEM_IDX_W+1:2];
    end

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_unit import ifetch_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             redirect_valid,
    input  wire  [XLEN-1:0] redirect_pc,
    input  wire             instr_ready,
    output logic            instr_valid,
    output logic [XLEN-1:0] instr_pc,
    output logic [XLEN-1:0] instr_data,
    fetch_if.requester      fetch
);

    logic [XLEN-1:0] pc;
    logic            busy;
    logic            discard;
    logic            buf_valid;
    logic [XLEN-1:0] buf_pc;
    logic [XLEN-1:0] buf_data;
    logic            req_fire;
    logic            resp_fire;
    logic            load;

    // one fetch in flight, only into an empty buffer
    assign fetch.req_valid  = !busy && !buf_valid;
    assign fetch.req_addr   = pc;
    assign fetch.resp_ready = !buf_valid;

    assign req_fire  = fetch.req_valid && fetch.req_ready;
    assign resp_fire = fetch.resp_valid && fetch.resp_ready;

    // a redirect in the same cycle drops the word too
    assign load = resp_fire && !discard && !redirect_valid;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc        <= RESET_PC;
            busy      <= 1'b0;
            discard   <= 1'b0;
            buf_valid <= 1'b0;
        end
        else
        begin
            if (req_fire)
                busy <= 1'b1;
            else if (resp_fire)
                busy <= 1'b0;

            if (redirect_valid)
            begin
                pc        <= redirect_pc;
                buf_valid <= 1'b0;
                // fetch still on its way for the old pc
                discard   <= req_fire || (busy && !resp_fire);
            end
            else
            begin
                if (resp_fire)
                    discard <= 1'b0;
                if (load)
                begin
                    buf_valid <= 1'b1;
                    pc        <= pc + XLEN'(4);
                end
                else if (buf_valid && instr_ready)
                begin
                    buf_valid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            buf_pc   <= pc;
            buf_data <= fetch.resp_data;
        end
    end

    assign instr_valid = buf_valid;
    assign instr_pc    = buf_pc;
    assign instr_data  = buf_data;

endmodule

`default_nettype wire

// ==== design/icache.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache import ifetch_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   flush,
    output logic [MISS_CNT_W-1:0] miss_count,
    fetch_if.responder            cpu,
    mem_if.requester              mem
);

    icache_line_t       lines [CACHE_LINES];
    icache_state_t      state;
    logic [XLEN-1:0]    addr_q;
    logic [INDEX_W-1:0] addr_idx;
    logic [TAG_W-1:0]   addr_tag;
    logic               hit;
    logic               mem_sent;
    logic               flush_pend;
    logic               do_flush;

    // index is bits 5:2, tag is bits 15:6
    assign addr_idx = addr_q[INDEX_W+1:2];
    assign addr_tag = addr_q[TAG_W+INDEX_W+1:INDEX_W+2];
    assign hit      = lines[addr_idx].valid && (lines[addr_idx].tag == addr_tag);

    // a flush waits for the FSM to come back to idle
    assign do_flush = (state == IDLE) && (flush || flush_pend);

    assign cpu.req_ready  = (state == IDLE);
    assign cpu.resp_valid = (state == RESPOND);
    assign cpu.resp_data  = lines[addr_idx].data;

    assign mem.req_valid = (state == REFILL) && !mem_sent;
    assign mem.req_addr  = {addr_q[XLEN-1:2], 2'b00};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= IDLE;
            mem_sent   <= 1'b0;
            flush_pend <= 1'b0;
            miss_count <= '0;
        end
        else
        begin
            if (do_flush)
                flush_pend <= 1'b0;
            else if (flush)
                flush_pend <= 1'b1;

            case (state)
                IDLE:
                begin
                    if (cpu.req_valid)
                        state <= LOOKUP;
                end
                LOOKUP:
                begin
                    if (hit)
                    begin
                        state <= RESPOND;
                    end
                    else
                    begin
                        state <= REFILL;
                        // saturate
                        if (miss_count != '1)
                            miss_count <= miss_count + 1'b1;
                    end
                end
                REFILL:
                begin
                    if (mem.req_valid && mem.req_ready)
                        mem_sent <= 1'b1;
                    if (mem.resp_valid)
                    begin
                        mem_sent <= 1'b0;
                        state    <= RESPOND;
                    end
                end
                RESPOND:
                begin
                    if (cpu.resp_ready)
                        state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (cpu.req_valid && cpu.req_ready)
            addr_q <= cpu.req_addr;
    end

    // line array, valid bits cleared on reset and flush
    always_ff @(posedge clk)
    begin
        if (rst || do_flush)
        begin
            for (int i = 0; i < CACHE_LINES; i++)
                lines[i].valid <= 1'b0;
        end
        else if ((state == REFILL) && mem.resp_valid)
        begin
            lines[addr_idx] <= '{valid: 1'b1, tag: addr_tag, data: mem.resp_data};
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface mem_if import ifetch_pkg::*; ();

    logic            req_valid;
    logic            req_ready;
    logic [XLEN-1:0] req_addr;
    logic            resp_valid;
    logic [XLEN-1:0] resp_data;

    // cache side, read only
    modport requester (
        output req_valid, req_addr,
        input  req_ready, resp_valid, resp_data
    );

    // memory side
    modport responder (
        input  req_valid, req_addr,
        output req_ready, resp_valid, resp_data
    );

endinterface

`default_nettype wire

// ==== design/fetch_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface fetch_if import ifetch_pkg::*; ();

    logic            req_valid;
    logic            req_ready;
    logic [XLEN-1:0] req_addr;
    logic            resp_valid;
    logic            resp_ready;
    logic [XLEN-1:0] resp_data;

    // fetch unit side
    modport requester (
        output req_valid, req_addr, resp_ready,
        input  req_ready, resp_valid, resp_data
    );

    // cache side
    modport responder (
        input  req_valid, req_addr, resp_ready,
        output req_ready, resp_valid, resp_data
    );

endinterface

`default_nettype wire

// ==== design/ifetch_pkg.sv ====
`default_nettype none

package ifetch_pkg;

    // datapath width
    localparam int XLEN = 32;

    // direct-mapped, one word per line
    localparam int CACHE_LINES = 16;
    localparam int INDEX_W     = 4;
    localparam int TAG_W       = 10;

    // backing memory, wraps every 128 bytes
    localparam int MEM_WORDS   = 32;
    localparam int MEM_IDX_W   = 5;
    localparam int MEM_LATENCY = 3;
    localparam int MEM_CNT_W   = $clog2(MEM_LATENCY + 1);

    localparam logic [XLEN-1:0] RESET_PC = '0;

    localparam int MISS_CNT_W = 16;

    // 1 + 10 + 32 bits
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  data;
    } icache_line_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        RESPOND
    } icache_state_t;

endpackage

`default_nettype wire
